//--- mips_defs.svh
// MIPS32 core widths and constants shared by the pipeline
// Data path, register index and register file depth
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define DATA_W    32
`define REG_AW    5
`define NUM_REGS  32

`define ZERO_WORD {`DATA_W{1'b0}}

`endif

//--- mips_pkg.sv
// MIPS32 core encodings
// Primary opcodes, SPECIAL function codes and internal ALU operations
`default_nettype none

package mips_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        SP_SLL  = 6'h00,
        SP_SRL  = 6'h02,
        SP_SRA  = 6'h03,
        SP_SLLV = 6'h04,
        SP_SRLV = 6'h06,
        SP_SRAV = 6'h07,
        SP_MOVZ = 6'h0a,
        SP_MOVN = 6'h0b,
        SP_ADD  = 6'h20,
        SP_ADDU = 6'h21,
        SP_SUB  = 6'h22,
        SP_SUBU = 6'h23,
        SP_AND  = 6'h24,
        SP_OR   = 6'h25,
        SP_XOR  = 6'h26,
        SP_NOR  = 6'h27,
        SP_SLT  = 6'h2a,
        SP_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MOVZ, ALU_MOVN,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU
    } alu_op_e;

endpackage

`default_nettype wire

//--- decode.sv
// Instruction decoder for the register and immediate ALU subset
// Picks each operand from EX, MEM, the register file or the immediate
`default_nettype none
`include "mips_defs.svh"

module decode (
    input  wire logic [31:0]           inst,
    input  wire logic                  inst_valid,
    output logic                       r1read,
    output logic [`REG_AW-1:0]         r1addr,
    output logic                       r2read,
    output logic [`REG_AW-1:0]         r2addr,
    input  wire logic [`DATA_W-1:0]    r1data,
    input  wire logic [`DATA_W-1:0]    r2data,
    output logic [`DATA_W-1:0]         opr1,
    output logic [`DATA_W-1:0]         opr2,
    output mips_pkg::alu_op_e          aluop,
    output logic                       wreg,
    output logic [`REG_AW-1:0]         wraddr,
    output logic                       illegal,
    input  wire logic                  ex_wreg,
    input  wire logic [`REG_AW-1:0]    ex_wraddr,
    input  wire logic [`DATA_W-1:0]    ex_alures,
    input  wire logic                  mem_wreg,
    input  wire logic [`REG_AW-1:0]    mem_wraddr,
    input  wire logic [`DATA_W-1:0]    mem_alures
);

    mips_pkg::opcode_e   opcode;
    mips_pkg::funct_e    funct;
    logic [4:0]          rs;
    logic [4:0]          rt;
    logic [4:0]          rd;
    logic [4:0]          sa;
    logic [15:0]         imm;
    logic [`DATA_W-1:0]  ext_imm;
    logic                legal;
    logic                const_shift;
    logic                ex_r1_haz;
    logic                ex_r2_haz;
    logic                mem_r1_haz;
    logic                mem_r2_haz;

    assign opcode = mips_pkg::opcode_e'(inst[31:26]);
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign sa     = inst[10:6];
    assign funct  = mips_pkg::funct_e'(inst[5:0]);
    assign imm    = inst[15:0];

    assign const_shift = (funct == mips_pkg::SP_SLL) || (funct == mips_pkg::SP_SRL) ||
                         (funct == mips_pkg::SP_SRA);

    always_comb begin
        legal   = 1'b0;
        aluop   = mips_pkg::ALU_NOP;
        r1read  = 1'b0;
        r2read  = 1'b0;
        r1addr  = rs;
        r2addr  = rt;
        wraddr  = rd;
        ext_imm = `ZERO_WORD;

        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                legal   = const_shift ? (rs == 5'd0) : (sa == 5'd0);
                r1read  = !const_shift;           // Constant shifts take sa as operand 1
                r2read  = 1'b1;
                ext_imm = {27'd0, sa};
                case (funct)
                    mips_pkg::SP_SLL,  mips_pkg::SP_SLLV: aluop = mips_pkg::ALU_SLL;
                    mips_pkg::SP_SRL,  mips_pkg::SP_SRLV: aluop = mips_pkg::ALU_SRL;
                    mips_pkg::SP_SRA,  mips_pkg::SP_SRAV: aluop = mips_pkg::ALU_SRA;
                    mips_pkg::SP_MOVZ: aluop = mips_pkg::ALU_MOVZ;
                    mips_pkg::SP_MOVN: aluop = mips_pkg::ALU_MOVN;
                    mips_pkg::SP_ADD:  aluop = mips_pkg::ALU_ADD;
                    mips_pkg::SP_ADDU: aluop = mips_pkg::ALU_ADDU;
                    mips_pkg::SP_SUB:  aluop = mips_pkg::ALU_SUB;
                    mips_pkg::SP_SUBU: aluop = mips_pkg::ALU_SUBU;
                    mips_pkg::SP_AND:  aluop = mips_pkg::ALU_AND;
                    mips_pkg::SP_OR:   aluop = mips_pkg::ALU_OR;
                    mips_pkg::SP_XOR:  aluop = mips_pkg::ALU_XOR;
                    mips_pkg::SP_NOR:  aluop = mips_pkg::ALU_NOR;
                    mips_pkg::SP_SLT:  aluop = mips_pkg::ALU_SLT;
                    mips_pkg::SP_SLTU: aluop = mips_pkg::ALU_SLTU;
                    default:           legal = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
                legal   = 1'b1;
                r1read  = 1'b1;
                wraddr  = rt;
                ext_imm = {{16{imm[15]}}, imm};
                case (opcode)
                    mips_pkg::OP_ADDI:  aluop = mips_pkg::ALU_ADD;
                    mips_pkg::OP_ADDIU: aluop = mips_pkg::ALU_ADDU;
                    mips_pkg::OP_SLTI:  aluop = mips_pkg::ALU_SLT;
                    mips_pkg::OP_SLTIU: aluop = mips_pkg::ALU_SLTU; // Sign-extended, compared unsigned
                    mips_pkg::OP_ANDI: begin
                        aluop   = mips_pkg::ALU_AND;
                        ext_imm = {16'd0, imm};
                    end
                    mips_pkg::OP_ORI: begin
                        aluop   = mips_pkg::ALU_OR;
                        ext_imm = {16'd0, imm};
                    end
                    mips_pkg::OP_XORI: begin
                        aluop   = mips_pkg::ALU_XOR;
                        ext_imm = {16'd0, imm};
                    end
                    default: begin
                        aluop   = mips_pkg::ALU_OR;  // LUI ors the shifted immediate into r0
                        ext_imm = {imm, 16'd0};
                        legal   = (rs == 5'd0);
                    end
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    // Register 0 is never a forwarding source
    assign ex_r1_haz  = ex_wreg  && (ex_wraddr  == r1addr) && (r1addr != '0);
    assign ex_r2_haz  = ex_wreg  && (ex_wraddr  == r2addr) && (r2addr != '0);
    assign mem_r1_haz = mem_wreg && (mem_wraddr == r1addr) && (r1addr != '0);
    assign mem_r2_haz = mem_wreg && (mem_wraddr == r2addr) && (r2addr != '0);

    always_comb begin
        if (!r1read)
            opr1 = ext_imm;
        else if (ex_r1_haz)
            opr1 = ex_alures;
        else if (mem_r1_haz)
            opr1 = mem_alures;
        else
            opr1 = r1data;                        // Includes WB write-through

        if (!r2read)
            opr2 = ext_imm;
        else if (ex_r2_haz)
            opr2 = ex_alures;
        else if (mem_r2_haz)
            opr2 = mem_alures;
        else
            opr2 = r2data;
    end

    always_comb begin
        wreg = inst_valid && legal;
        if (aluop == mips_pkg::ALU_MOVZ)
            wreg = wreg && (opr2 == `ZERO_WORD);
        else if (aluop == mips_pkg::ALU_MOVN)
            wreg = wreg && (opr2 != `ZERO_WORD);
    end

    assign illegal = inst_valid && !legal;

    // A read of r0 must see zero whatever is in flight in EX or MEM
    always_comb begin
        assert #0 (!(r1read && r1addr == '0) || opr1 == `ZERO_WORD);
    end

endmodule

`default_nettype wire

//--- regfile.sv
// 32-entry register file, two read ports and one write port
// Register 0 reads zero; a read of the address being written returns the write data
`default_nettype none
`include "mips_defs.svh"

module regfile (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [`REG_AW-1:0]    raddr1,
    input  wire logic [`REG_AW-1:0]    raddr2,
    output logic [`DATA_W-1:0]         rdata1,
    output logic [`DATA_W-1:0]         rdata2,
    input  wire logic                  wen,
    input  wire logic [`REG_AW-1:0]    waddr,
    input  wire logic [`DATA_W-1:0]    wdata
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= `ZERO_WORD;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    function automatic logic [`DATA_W-1:0] read_port(input logic [`REG_AW-1:0] addr);
        if (addr == '0)
            return `ZERO_WORD;
        if (wen && addr == waddr)
            return wdata;                         // WB write-through
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

`default_nettype wire

//--- ex_stage.sv
// Execute stage with the ID/EX register and the ALU
// Signed overflow on ADD, SUB and ADDI cancels the write and pulses overflow
`default_nettype none
`include "mips_defs.svh"

module ex_stage (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [`DATA_W-1:0]    opr1,
    input  wire logic [`DATA_W-1:0]    opr2,
    input  wire mips_pkg::alu_op_e     aluop,
    input  wire logic                  wreg,
    input  wire logic [`REG_AW-1:0]    wraddr,
    input  wire logic                  illegal,
    output logic                       ex_wreg,
    output logic [`REG_AW-1:0]         ex_wraddr,
    output logic [`DATA_W-1:0]         ex_alures,
    output logic                       overflow,
    output logic                       illegal_inst
);

    mips_pkg::alu_op_e   aluop_q;
    logic                wreg_q;
    logic                illegal_q;
    logic [`DATA_W-1:0]  opr1_q;
    logic [`DATA_W-1:0]  opr2_q;
    logic [`REG_AW-1:0]  wraddr_q;
    logic [`DATA_W-1:0]  sum;
    logic [`DATA_W-1:0]  diff;
    logic                add_ovf;
    logic                sub_ovf;
    logic [`DATA_W:0]    sum_x;
    logic [`DATA_W:0]    diff_x;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aluop_q   <= mips_pkg::ALU_NOP;
            wreg_q    <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            aluop_q   <= aluop;
            wreg_q    <= wreg;
            illegal_q <= illegal;
        end
    end

    always_ff @(posedge clk) begin
        opr1_q   <= opr1;
        opr2_q   <= opr2;
        wraddr_q <= wraddr;
    end

    assign sum  = opr1_q + opr2_q;
    assign diff = opr1_q - opr2_q;

    always_comb begin
        case (aluop_q)
            mips_pkg::ALU_SLL:  ex_alures = opr2_q << opr1_q[4:0];
            mips_pkg::ALU_SRL:  ex_alures = opr2_q >> opr1_q[4:0];
            mips_pkg::ALU_SRA:  ex_alures = $unsigned($signed(opr2_q) >>> opr1_q[4:0]);
            mips_pkg::ALU_MOVZ,
            mips_pkg::ALU_MOVN: ex_alures = opr1_q;     // Write was already decided in decode
            mips_pkg::ALU_ADD,
            mips_pkg::ALU_ADDU: ex_alures = sum;
            mips_pkg::ALU_SUB,
            mips_pkg::ALU_SUBU: ex_alures = diff;
            mips_pkg::ALU_AND:  ex_alures = opr1_q & opr2_q;
            mips_pkg::ALU_OR:   ex_alures = opr1_q | opr2_q;
            mips_pkg::ALU_XOR:  ex_alures = opr1_q ^ opr2_q;
            mips_pkg::ALU_NOR:  ex_alures = ~(opr1_q | opr2_q);
            mips_pkg::ALU_SLT:  ex_alures = {31'd0, $signed(opr1_q) < $signed(opr2_q)};
            mips_pkg::ALU_SLTU: ex_alures = {31'd0, opr1_q < opr2_q};
            default:            ex_alures = `ZERO_WORD;
        endcase
    end

    // Operand signs agree but the result sign differs
    assign add_ovf = (opr1_q[`DATA_W-1] == opr2_q[`DATA_W-1]) &&
                     (sum[`DATA_W-1] != opr1_q[`DATA_W-1]);
    assign sub_ovf = (opr1_q[`DATA_W-1] != opr2_q[`DATA_W-1]) &&
                     (diff[`DATA_W-1] != opr1_q[`DATA_W-1]);

    assign overflow = wreg_q && ((aluop_q == mips_pkg::ALU_ADD && add_ovf) ||
                                 (aluop_q == mips_pkg::ALU_SUB && sub_ovf));

    assign ex_wreg      = wreg_q && !overflow;
    assign ex_wraddr    = wraddr_q;
    assign illegal_inst = illegal_q;

    assign sum_x  = {opr1_q[`DATA_W-1], opr1_q} + {opr2_q[`DATA_W-1], opr2_q};
    assign diff_x = {opr1_q[`DATA_W-1], opr1_q} - {opr2_q[`DATA_W-1], opr2_q};

    // An overflowing result never reaches forwarding or retirement, and its
    // full-width value really leaves the signed range
    a_ovf_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        overflow |-> !ex_wreg && ((aluop_q == mips_pkg::ALU_ADD) ?
                                  (sum_x[`DATA_W] != sum_x[`DATA_W-1]) :
                                  (diff_x[`DATA_W] != diff_x[`DATA_W-1])));

endmodule

`default_nettype wire

//--- retire_pipe.sv
// EX/MEM and MEM/WB pipeline registers
// MEM feeds forwarding; WB drives the register file write port
`default_nettype none
`include "mips_defs.svh"

module retire_pipe (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  ex_wreg,
    input  wire logic [`REG_AW-1:0]    ex_wraddr,
    input  wire logic [`DATA_W-1:0]    ex_alures,
    output logic                       mem_wreg,
    output logic [`REG_AW-1:0]         mem_wraddr,
    output logic [`DATA_W-1:0]         mem_alures,
    output logic                       wb_en,
    output logic [`REG_AW-1:0]         wb_addr,
    output logic [`DATA_W-1:0]         wb_data
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wreg <= 1'b0;
            wb_en    <= 1'b0;
        end else begin
            mem_wreg <= ex_wreg;
            wb_en    <= mem_wreg;
        end
    end

    always_ff @(posedge clk) begin
        mem_wraddr <= ex_wraddr;
        mem_alures <= ex_alures;
        wb_addr    <= mem_wraddr;
        wb_data    <= mem_alures;
    end

    // Bubbles from idle cycles must still carry a clean write enable
    a_wb_en_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(wb_en));

endmodule

`default_nettype wire

//--- mips_core.sv
// MIPS32 integer pipeline core, top level
// Decode, register file, execute and the retire registers up to writeback
`default_nettype none
`include "mips_defs.svh"

module mips_core (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [31:0]           inst,
    input  wire logic                  inst_valid,
    output logic                       wb_en,
    output logic [`REG_AW-1:0]         wb_addr,
    output logic [`DATA_W-1:0]         wb_data,
    output logic                       overflow,
    output logic                       illegal_inst
);

    logic [`REG_AW-1:0]  r1addr;
    logic [`REG_AW-1:0]  r2addr;
    logic [`DATA_W-1:0]  r1data;
    logic [`DATA_W-1:0]  r2data;
    logic [`DATA_W-1:0]  opr1;
    logic [`DATA_W-1:0]  opr2;
    mips_pkg::alu_op_e   aluop;
    logic                wreg;
    logic [`REG_AW-1:0]  wraddr;
    logic                illegal;
    logic                ex_wreg;
    logic [`REG_AW-1:0]  ex_wraddr;
    logic [`DATA_W-1:0]  ex_alures;
    logic                mem_wreg;
    logic [`REG_AW-1:0]  mem_wraddr;
    logic [`DATA_W-1:0]  mem_alures;

    // The register file reads every cycle, so the read strobes stay inside decode
    decode decode_i (
        .inst       (inst),
        .inst_valid (inst_valid),
        .r1read     (),
        .r1addr     (r1addr),
        .r2read     (),
        .r2addr     (r2addr),
        .r1data     (r1data),
        .r2data     (r2data),
        .opr1       (opr1),
        .opr2       (opr2),
        .aluop      (aluop),
        .wreg       (wreg),
        .wraddr     (wraddr),
        .illegal    (illegal),
        .ex_wreg    (ex_wreg),
        .ex_wraddr  (ex_wraddr),
        .ex_alures  (ex_alures),
        .mem_wreg   (mem_wreg),
        .mem_wraddr (mem_wraddr),
        .mem_alures (mem_alures)
    );

    regfile regfile_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (r1addr),
        .raddr2 (r2addr),
        .rdata1 (r1data),
        .rdata2 (r2data),
        .wen    (wb_en),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

    ex_stage ex_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .opr1         (opr1),
        .opr2         (opr2),
        .aluop        (aluop),
        .wreg         (wreg),
        .wraddr       (wraddr),
        .illegal      (illegal),
        .ex_wreg      (ex_wreg),
        .ex_wraddr    (ex_wraddr),
        .ex_alures    (ex_alures),
        .overflow     (overflow),
        .illegal_inst (illegal_inst)
    );

    retire_pipe retire_pipe_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_wreg    (ex_wreg),
        .ex_wraddr  (ex_wraddr),
        .ex_alures  (ex_alures),
        .mem_wreg   (mem_wreg),
        .mem_wraddr (mem_wraddr),
        .mem_alures (mem_alures),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

//--- tb_mips_core.sv
// Testbench for the MIPS32 pipeline core
// Table-driven stimulus checked against a reference model of the register file
`default_nettype none
`include "mips_defs.svh"

module tb_mips_core;

    logic                clk;
    logic                rst_n;
    logic [31:0]         inst;
    logic                inst_valid;
    logic                wb_en;
    logic [`REG_AW-1:0]  wb_addr;
    logic [`DATA_W-1:0]  wb_data;
    logic                overflow;
    logic                illegal_inst;
    logic [1:0]          ovf_d;
    logic [1:0]          ill_d;

    integer              seed = 39576;
    int                  cyc = 0;
    int                  errors = 0;
    int                  checks = 0;
    logic [`DATA_W-1:0]  ref_regs [`NUM_REGS];
    string               tbl_name [$];
    logic [31:0]         tbl_inst [$];
    logic                tbl_valid [$];
    int                  row_err [$];
    int                  exp_row [$];
    int                  exp_issue [$];
    logic [39:0]         exp_res [$];        // {ovf, ill, wen, waddr, wdata}

    mips_core mips_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .overflow     (overflow),
        .illegal_inst (illegal_inst)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Status pulses are delayed two cycles so they line up with writeback
    always @(posedge clk) begin
        cyc   <= cyc + 1;
        ovf_d <= {ovf_d[0], overflow};
        ill_d <= {ill_d[0], illegal_inst};
    end

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sa);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [4:0] rand_reg(input int lo, input int span);
        int r;
        r = $random(seed);
        return 5'(lo + ((r & 32'h7fff_ffff) % span));
    endfunction

    task automatic add_row(input string name, input logic [31:0] word, input logic valid);
        tbl_name.push_back(name);
        tbl_inst.push_back(word);
        tbl_valid.push_back(valid);
        row_err.push_back(0);
    endtask

    task automatic check(input int row, input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            row_err[row] = row_err[row] + 1;
            $display("FAIL %s %s: expected %h, actual %h", tbl_name[row], what, expected, actual);
        end
    endtask

    // Executes one row in program order and updates the model registers
    function automatic logic [39:0] model_step(input logic [31:0] word, input logic valid);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] se;
        logic [31:0] d;
        logic [32:0] wide;
        logic [4:0]  dst;
        logic        w;
        logic        ovf;
        logic        ill;
        logic        signed_op;
        a         = ref_regs[word[25:21]];
        b         = ref_regs[word[20:16]];
        se        = {{16{word[15]}}, word[15:0]};
        dst       = word[20:16];
        d         = '0;
        wide      = '0;
        w         = valid;
        ill       = 1'b0;
        signed_op = 1'b0;
        case (word[31:26])
            6'h00: begin
                dst = word[15:11];
                case (word[5:0])
                    6'h00: d = b << word[10:6];
                    6'h02: d = b >> word[10:6];
                    6'h03: d = $signed(b) >>> word[10:6];
                    6'h04: d = b << a[4:0];
                    6'h06: d = b >> a[4:0];
                    6'h07: d = $signed(b) >>> a[4:0];
                    6'h0a: begin
                        d = a;
                        w = valid && (b == '0);
                    end
                    6'h0b: begin
                        d = a;
                        w = valid && (b != '0);
                    end
                    6'h20: begin
                        wide      = {a[31], a} + {b[31], b};
                        signed_op = 1'b1;
                    end
                    6'h21: d = a + b;
                    6'h22: begin
                        wide      = {a[31], a} - {b[31], b};
                        signed_op = 1'b1;
                    end
                    6'h23: d = a - b;
                    6'h24: d = a & b;
                    6'h25: d = a | b;
                    6'h26: d = a ^ b;
                    6'h27: d = ~(a | b);
                    6'h2a: d = {31'd0, $signed(a) < $signed(b)};
                    6'h2b: d = {31'd0, a < b};
                    default: ill = 1'b1;
                endcase
            end
            6'h08: begin
                wide      = {a[31], a} + {se[31], se};
                signed_op = 1'b1;
            end
            6'h09: d = a + se;
            6'h0a: d = {31'd0, $signed(a) < $signed(se)};
            6'h0b: d = {31'd0, a < se};        // Sign-extended immediate, unsigned compare
            6'h0c: d = a & {16'd0, word[15:0]};
            6'h0d: d = a | {16'd0, word[15:0]};
            6'h0e: d = a ^ {16'd0, word[15:0]};
            6'h0f: d = {word[15:0], 16'd0};
            default: ill = 1'b1;
        endcase
        if (signed_op)
            d = wide[31:0];
        ovf = valid && signed_op && (wide[32] != wide[31]);  // Carry into sign differs from out
        ill = valid && ill;
        w   = w && !ill && !ovf;
        if (w && dst != 5'd0)
            ref_regs[dst] = d;
        return {ovf, ill, w, dst, d};
    endfunction

    task automatic build_table();
        logic [5:0] alu_fn [8];
        alu_fn = '{mips_pkg::SP_ADDU, mips_pkg::SP_SUBU, mips_pkg::SP_AND, mips_pkg::SP_OR,
                   mips_pkg::SP_XOR, mips_pkg::SP_NOR, mips_pkg::SP_SLT, mips_pkg::SP_SLTU};
        add_row("ori_r0", enc_i(mips_pkg::OP_ORI, 5'd0, 5'd1, 16'($random(seed))), 1'b1);
        add_row("addiu_r0", enc_i(mips_pkg::OP_ADDIU, 5'd0, 5'd2, 16'($random(seed))), 1'b1);
        add_row("andi_r0", enc_i(mips_pkg::OP_ANDI, 5'd0, 5'd3, 16'($random(seed))), 1'b1);
        add_row("xori_r0", enc_i(mips_pkg::OP_XORI, 5'd0, 5'd4, 16'($random(seed))), 1'b1);
        add_row("lui", enc_i(mips_pkg::OP_LUI, 5'd0, 5'd5, 16'($random(seed))), 1'b1);
        add_row("addiu_m1", enc_i(mips_pkg::OP_ADDIU, 5'd0, 5'd8, 16'hffff), 1'b1);
        add_row("slti_neg", enc_i(mips_pkg::OP_SLTI, 5'd8, 5'd6, 16'h0001), 1'b1);
        add_row("sltiu_neg", enc_i(mips_pkg::OP_SLTIU, 5'd8, 5'd7, 16'h0001), 1'b1);
        add_row("slti_rand", enc_i(mips_pkg::OP_SLTI, 5'd2, 5'd9, 16'($random(seed))), 1'b1);
        add_row("sltiu_rand", enc_i(mips_pkg::OP_SLTIU, 5'd5, 5'd9, 16'($random(seed))), 1'b1);
        // r11 is consumed at distances 1, 2 and 3
        add_row("dep_d1", enc_r(mips_pkg::SP_ADDU, 5'd1, 5'd2, 5'd11, 5'd0), 1'b1);
        add_row("dep_d1b", enc_r(mips_pkg::SP_SUBU, 5'd11, 5'd4, 5'd12, 5'd0), 1'b1);
        add_row("dep_d2", enc_r(mips_pkg::SP_XOR, 5'd11, 5'd5, 5'd13, 5'd0), 1'b1);
        add_row("dep_d3", enc_r(mips_pkg::SP_OR, 5'd11, 5'd12, 5'd14, 5'd0), 1'b1);
        add_row("dep_mix", enc_r(mips_pkg::SP_NOR, 5'd13, 5'd14, 5'd15, 5'd0), 1'b1);
        for (int i = 0; i < 12; i++) begin
            add_row($sformatf("alu_rand_%0d", i),
                    enc_r(alu_fn[3'(rand_reg(0, 8))], rand_reg(1, 15), rand_reg(1, 15),
                          rand_reg(10, 6), 5'd0), 1'b1);
        end
        add_row("sll", enc_r(mips_pkg::SP_SLL, 5'd0, 5'd5, 5'd16, rand_reg(1, 31)), 1'b1);
        add_row("srl", enc_r(mips_pkg::SP_SRL, 5'd0, 5'd8, 5'd17, rand_reg(1, 31)), 1'b1);
        add_row("sra", enc_r(mips_pkg::SP_SRA, 5'd0, 5'd16, 5'd18, rand_reg(1, 31)), 1'b1);
        add_row("sllv", enc_r(mips_pkg::SP_SLLV, 5'd1, 5'd5, 5'd19, 5'd0), 1'b1);
        add_row("srlv", enc_r(mips_pkg::SP_SRLV, 5'd2, 5'd19, 5'd19, 5'd0), 1'b1);
        add_row("srav", enc_r(mips_pkg::SP_SRAV, 5'd4, 5'd16, 5'd20, 5'd0), 1'b1);
        add_row("movz_take", enc_r(mips_pkg::SP_MOVZ, 5'd1, 5'd0, 5'd21, 5'd0), 1'b1);
        add_row("movn_skip", enc_r(mips_pkg::SP_MOVN, 5'd2, 5'd0, 5'd21, 5'd0), 1'b1);
        add_row("movn_take", enc_r(mips_pkg::SP_MOVN, 5'd2, 5'd8, 5'd22, 5'd0), 1'b1);
        add_row("movz_skip", enc_r(mips_pkg::SP_MOVZ, 5'd1, 5'd8, 5'd22, 5'd0), 1'b1);
        add_row("mov_after", enc_r(mips_pkg::SP_OR, 5'd21, 5'd22, 5'd23, 5'd0), 1'b1);
        add_row("lui_max", enc_i(mips_pkg::OP_LUI, 5'd0, 5'd23, 16'h7fff), 1'b1);
        add_row("ori_max", enc_i(mips_pkg::OP_ORI, 5'd23, 5'd23, 16'hffff), 1'b1);
        add_row("add_ovf", enc_r(mips_pkg::SP_ADD, 5'd23, 5'd23, 5'd24, 5'd0), 1'b1);
        add_row("addi_ovf", enc_i(mips_pkg::OP_ADDI, 5'd23, 5'd24, 16'h0001), 1'b1);
        add_row("addu_wrap", enc_r(mips_pkg::SP_ADDU, 5'd23, 5'd23, 5'd24, 5'd0), 1'b1);
        add_row("lui_min", enc_i(mips_pkg::OP_LUI, 5'd0, 5'd25, 16'h8000), 1'b1);
        add_row("sub_ovf", enc_r(mips_pkg::SP_SUB, 5'd25, 5'd23, 5'd26, 5'd0), 1'b1);
        add_row("sub_ok", enc_r(mips_pkg::SP_SUB, 5'd8, 5'd23, 5'd26, 5'd0), 1'b1);
        add_row("add_ok", enc_r(mips_pkg::SP_ADD, 5'd24, 5'd1, 5'd27, 5'd0), 1'b1);
        // r0 is read at distances 1, 2 and 3 after the write to it
        add_row("ori_to_r0", enc_i(mips_pkg::OP_ORI, 5'd0, 5'd0, 16'h1234), 1'b1);
        add_row("read_r0", enc_r(mips_pkg::SP_ADDU, 5'd0, 5'd0, 5'd28, 5'd0), 1'b1);
        add_row("read_r0_d2", enc_r(mips_pkg::SP_OR, 5'd0, 5'd0, 5'd28, 5'd0), 1'b1);
        add_row("read_r0_d3", enc_r(mips_pkg::SP_XOR, 5'd0, 5'd0, 5'd28, 5'd0), 1'b1);
        add_row("illegal_op", {6'h3f, 26'($random(seed))}, 1'b1);
        add_row("illegal_fn", enc_r(6'h01, 5'd1, 5'd2, 5'd29, 5'd0), 1'b1);
        for (int i = 0; i < 3; i++) begin
            add_row($sformatf("idle_%0d", i), 32'($random(seed)), 1'b0);
        end
        add_row("after_idle", enc_r(mips_pkg::SP_ADDU, 5'd11, 5'd24, 5'd30, 5'd0), 1'b1);
    endtask

    task automatic issue_row(input int row);
        inst       = tbl_inst[row];
        inst_valid = tbl_valid[row];
        exp_row.push_back(row);
        exp_issue.push_back(cyc);
        exp_res.push_back(model_step(tbl_inst[row], tbl_valid[row]));
    endtask

    // A row sampled at the edge after issue retires on wb three cycles later
    always @(negedge clk) begin
        int          row;
        logic [39:0] e;
        if (rst_n) begin
            if (exp_row.size() > 0 && exp_issue[0] == cyc - 3) begin
                row = exp_row.pop_front();
                e   = exp_res.pop_front();
                void'(exp_issue.pop_front());
                check(row, "overflow", 32'(e[39]), 32'(ovf_d[1]));
                check(row, "illegal_inst", 32'(e[38]), 32'(ill_d[1]));
                check(row, "wb_en", 32'(e[37]), 32'(wb_en));
                if (e[37]) begin
                    check(row, "wb_addr", 32'(e[36:32]), 32'(wb_addr));
                    check(row, "wb_data", e[31:0], wb_data);
                end
                $display("%-14s %s", tbl_name[row], (row_err[row] == 0) ? "ok" : "mismatch");
            end else if (wb_en !== 1'b0) begin
                errors++;
                $display("Writeback to r%0d appeared with no instruction due at cycle %0d",
                         wb_addr, cyc);
            end
        end
    end

    initial begin
        int timeout;
        rst_n      = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (tbl_inst[i]) begin
            issue_row(i);
            @(posedge clk);
            #1;
        end
        inst       = '0;
        inst_valid = 1'b0;
        timeout    = 0;
        while (exp_row.size() > 0 && timeout < 10) begin
            @(posedge clk);
            timeout++;
        end
        if (exp_row.size() > 0) begin
            errors++;
            $display("Timed out with %0d rows still waiting for writeback", exp_row.size());
        end
        repeat (3) @(posedge clk);              // Idle tail, stray writebacks still flagged
        $display("tests %0d, checks %0d, errors %0d", tbl_inst.size(), checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
mips_pkg.sv
decode.sv
regfile.sv
ex_stage.sv
retire_pipe.sv
mips_core.sv
tb_mips_core.sv

//--- Makefile
# Verilator build and run for the MIPS32 pipeline core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_mips_core
RTL_TOP   := mips_core
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
